// ==== design/calc_types_pkg.sv ====
// data width and vector types shared by the arithmetic unit
// pulled in by scoped name wherever operands or shift amounts appear
package calc_types_pkg;

  // default operand width, calc_top takes its WIDTH parameter from here
  localparam int WORD_WIDTH = 16;

  // bits needed to shift across a full word
  localparam int SHAMT_WIDTH = $clog2(WORD_WIDTH);

  // operand, accumulator and result vector
  typedef logic [WORD_WIDTH-1:0] word_t;

  // shift amount, sliced from the right operand
  typedef logic [SHAMT_WIDTH-1:0] shamt_t;

endpackage

// ==== design/calc_op_pkg.sv ====
// opcode type and named opcode values for the request interface
// codes outside this list return zero
package calc_op_pkg;

  typedef logic [3:0] op_t;

  // single step operators
  localparam op_t OP_AND = 4'h0;
  localparam op_t OP_OR  = 4'h1;
  localparam op_t OP_XOR = 4'h2;
  localparam op_t OP_SUB = 4'h3;
  localparam op_t OP_LSH = 4'h4;
  localparam op_t OP_RSH = 4'h5;

  // compares, one bit result padded with zeros
  localparam op_t OP_LT  = 4'h6;
  localparam op_t OP_EQ  = 4'h7;

  // iterative operations
  localparam op_t OP_MUL = 4'h8;
  localparam op_t OP_GCD = 4'h9;

endpackage

// ==== design/calc_core_ops.sv ====
// combinational operator block, the primitive library of the unit
// op picks one of the core operators applied to left and right
`timescale 1ns/10ps

module calc_core_ops #(
  parameter int WIDTH = calc_types_pkg::WORD_WIDTH
) (
  input  calc_op_pkg::op_t     op,
  input  calc_types_pkg::word_t left,
  input  calc_types_pkg::word_t right,
  output calc_types_pkg::word_t out,
  output logic                  cmp
);

  calc_types_pkg::shamt_t shamt;
  calc_types_pkg::word_t  and_out;
  calc_types_pkg::word_t  or_out;
  calc_types_pkg::word_t  xor_out;
  calc_types_pkg::word_t  sub_out;
  calc_types_pkg::word_t  lsh_out;
  calc_types_pkg::word_t  rsh_out;
  calc_types_pkg::word_t  lt_out;
  calc_types_pkg::word_t  eq_out;
  logic                   lt_bit;
  logic                   eq_bit;

  // slice the low bits of right as the shift amount
  assign shamt = right[$bits(calc_types_pkg::shamt_t)-1:0];

  assign and_out = left & right;
  assign or_out  = left | right;
  assign xor_out = left ^ right;
  assign sub_out = left - right;
  assign lsh_out = left << shamt;
  assign rsh_out = left >> shamt;

  assign lt_bit = left < right;
  assign eq_bit = left == right;

  // pad compare bits up to a full word
  assign lt_out = {{(WIDTH-1){1'b0}}, lt_bit};
  assign eq_out = {{(WIDTH-1){1'b0}}, eq_bit};

  // the fsm orders the gcd subtraction with this
  assign cmp = lt_bit;

  always_comb begin
    case (op)
      calc_op_pkg::OP_AND: begin
        out = and_out;
      end
      calc_op_pkg::OP_OR: begin
        out = or_out;
      end
      calc_op_pkg::OP_XOR: begin
        out = xor_out;
      end
      calc_op_pkg::OP_SUB: begin
        out = sub_out;
      end
      calc_op_pkg::OP_LSH: begin
        out = lsh_out;
      end
      calc_op_pkg::OP_RSH: begin
        out = rsh_out;
      end
      calc_op_pkg::OP_LT: begin
        out = lt_out;
      end
      calc_op_pkg::OP_EQ: begin
        out = eq_out;
      end
      default: begin
        // mul, gcd and undefined codes have no single operator
        out = '0;
      end
    endcase
  end

endmodule

// ==== design/calc_operand_regs.sv ====
// operand and accumulator registers for the iterative unit
// load captures a request, step advances one multiply or gcd iteration
`timescale 1ns/10ps

module calc_operand_regs #(
  parameter int WIDTH = calc_types_pkg::WORD_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load,
  input  logic                  step,
  input  calc_op_pkg::op_t      mode,
  input  calc_types_pkg::word_t a,
  input  calc_types_pkg::word_t b,
  input  calc_types_pkg::word_t alu_out,
  input  logic                  cmp,
  output calc_types_pkg::word_t acc,
  output calc_types_pkg::word_t opa,
  output calc_types_pkg::word_t opb,
  output logic                  opa_zero,
  output logic                  opb_zero,
  output logic                  ops_equal
);

  calc_types_pkg::word_t neg_diff;
  logic                  mul_mode;
  logic                  gcd_mode;

  assign mul_mode = (mode == calc_op_pkg::OP_MUL);
  assign gcd_mode = (mode == calc_op_pkg::OP_GCD);

  // alu gives opa - opb, flip it when opb is the larger one
  assign neg_diff = ~alu_out + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= '0;
      opa <= '0;
      opb <= '0;
    end else if (load) begin
      opa <= a;
      opb <= b;
      acc <= '0;
    end else if (step) begin
      if (mul_mode) begin
        // shift and add, one multiplier bit per step
        if (opb[0]) begin
          acc <= acc + opa;
        end
        opa <= {opa[WIDTH-2:0], 1'b0};
        opb <= {1'b0, opb[WIDTH-1:1]};
      end else if (gcd_mode) begin
        // larger operand takes the difference
        if (cmp) begin
          opb <= neg_diff;
        end else begin
          opa <= alu_out;
        end
      end
    end
  end

  // loop exit conditions for the fsm
  assign opa_zero  = (opa == '0);
  assign opb_zero  = (opb == '0);
  assign ops_equal = (opa == opb);

endmodule

// ==== design/calc_step_counter.sv ====
// multiply step counter, restarts at zero on cnt_load
// last flags the step that reaches STEPS-1
`timescale 1ns/10ps

module calc_step_counter #(
  parameter int STEPS = calc_types_pkg::WORD_WIDTH
) (
  input  logic clk,
  input  logic rst_n,
  input  logic cnt_load,
  input  logic cnt_en,
  output logic last
);

  localparam int CNT_WIDTH = (STEPS > 1) ? $clog2(STEPS) : 1;

  logic [CNT_WIDTH-1:0] count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (cnt_load) begin
      count <= '0;
    end else if (cnt_en) begin
      count <= count + 1'b1;
    end
  end

  assign last = (count == CNT_WIDTH'(STEPS - 1));

endmodule

// ==== design/calc_fsm.sv ====
// handshake and sequencing fsm of the unit
// steers operand registers, step counter and operator choice per opcode
`timescale 1ns/10ps

module calc_fsm (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req,
  output logic             ack,
  input  calc_op_pkg::op_t op,
  output logic             load,
  output logic             step,
  output logic             cnt_load,
  output logic             cnt_en,
  output calc_op_pkg::op_t alu_op,
  output logic             result_sel,
  input  logic             opa_zero,
  input  logic             opb_zero,
  input  logic             ops_equal,
  input  logic             last
);

  typedef enum logic [2:0] {IDLE, LOAD, EXEC, LOOP, DONE} state_t;

  state_t state;
  state_t state_next;
  logic   is_mul;
  logic   is_gcd;
  logic   gcd_done;

  assign is_mul   = (op == calc_op_pkg::OP_MUL);
  assign is_gcd   = (op == calc_op_pkg::OP_GCD);
  assign gcd_done = opa_zero | opb_zero | ops_equal;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      ack   <= 1'b0;
    end else begin
      state <= state_next;
      // ack follows req while the result is held
      ack   <= (state == DONE) && req;
    end
  end

  always_comb begin
    state_next = state;
    load       = 1'b0;
    step       = 1'b0;
    cnt_load   = 1'b0;
    cnt_en     = 1'b0;
    alu_op     = op;
    result_sel = 1'b0;
    case (state)
      IDLE: begin
        if (req) begin
          state_next = LOAD;
        end
      end
      LOAD: begin
        load       = 1'b1;
        cnt_load   = is_mul;
        state_next = (is_mul || is_gcd) ? LOOP : EXEC;
      end
      EXEC: begin
        result_sel = 1'b1;
        state_next = DONE;
      end
      LOOP: begin
        if (is_mul) begin
          step   = 1'b1;
          cnt_en = 1'b1;
          if (last) begin
            state_next = DONE;
          end
        end else begin
          alu_op = calc_op_pkg::OP_SUB;
          if (gcd_done) begin
            state_next = DONE;
          end else begin
            step = 1'b1;
          end
        end
      end
      DONE: begin
        // loops capture once, or of the final operands gives the answer
        if (!ack && (is_mul || is_gcd)) begin
          alu_op     = calc_op_pkg::OP_OR;
          result_sel = 1'b1;
        end
        if (!req) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

endmodule

// ==== design/calc_top.sv ====
// top of the iterative arithmetic unit with a four-phase req/ack port
// sets the data width and owns the result register
`timescale 1ns/10ps

module calc_top #(
  parameter int WIDTH = calc_types_pkg::WORD_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  calc_op_pkg::op_t      op,
  input  calc_types_pkg::word_t a,
  input  calc_types_pkg::word_t b,
  output logic                  ack,
  output calc_types_pkg::word_t result
);

  logic                  load;
  logic                  step;
  logic                  cnt_load;
  logic                  cnt_en;
  logic                  result_sel;
  logic                  last;
  logic                  cmp;
  logic                  opa_zero;
  logic                  opb_zero;
  logic                  ops_equal;
  calc_op_pkg::op_t      alu_op;
  calc_types_pkg::word_t acc;
  calc_types_pkg::word_t opa;
  calc_types_pkg::word_t opb;
  calc_types_pkg::word_t alu_left;
  calc_types_pkg::word_t alu_out;

  // product sits in acc, opb has shifted out to zero by then
  assign alu_left = (op == calc_op_pkg::OP_MUL) ? acc : opa;

  always_ff @(posedge clk) begin
    if (result_sel) begin
      result <= alu_out;
    end
  end

  calc_fsm i_calc_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .ack        (ack),
    .op         (op),
    .load       (load),
    .step       (step),
    .cnt_load   (cnt_load),
    .cnt_en     (cnt_en),
    .alu_op     (alu_op),
    .result_sel (result_sel),
    .opa_zero   (opa_zero),
    .opb_zero   (opb_zero),
    .ops_equal  (ops_equal),
    .last       (last)
  );

  calc_operand_regs #(.WIDTH(WIDTH)) i_calc_operand_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .step      (step),
    .mode      (op),
    .a         (a),
    .b         (b),
    .alu_out   (alu_out),
    .cmp       (cmp),
    .acc       (acc),
    .opa       (opa),
    .opb       (opb),
    .opa_zero  (opa_zero),
    .opb_zero  (opb_zero),
    .ops_equal (ops_equal)
  );

  calc_step_counter #(.STEPS(WIDTH)) i_calc_step_counter (
    .clk      (clk),
    .rst_n    (rst_n),
    .cnt_load (cnt_load),
    .cnt_en   (cnt_en),
    .last     (last)
  );

  calc_core_ops #(.WIDTH(WIDTH)) i_calc_core_ops (
    .op    (alu_op),
    .left  (alu_left),
    .right (opb),
    .out   (alu_out),
    .cmp   (cmp)
  );

endmodule

// ==== bench/calc_clock_gen.sv ====
// clock and reset source for the arithmetic unit testbench
`timescale 1ns/10ps

module calc_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset held low over the first three rising edges
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== bench/calc_tb.sv ====
// testbench for the iterative arithmetic unit
// random four-phase requests from a fixed seed, checked against an in-bench model
`timescale 1ns/10ps

module calc_tb;

  localparam int WIDTH       = calc_types_pkg::WORD_WIDTH;
  localparam int NUM_TESTS   = 200;
  localparam int MAX_CYCLES  = 256 + 20;
  localparam int CYCLE_LIMIT = NUM_TESTS * MAX_CYCLES + 20;

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  calc_op_pkg::op_t      op;
  calc_types_pkg::word_t a;
  calc_types_pkg::word_t b;
  logic                  ack;
  calc_types_pkg::word_t result;

  int seed;
  int errors;
  int failed_tests;
  int cycles;

  calc_clock_gen i_calc_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  calc_top #(.WIDTH(WIDTH)) i_calc_top (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .op     (op),
    .a      (a),
    .b      (b),
    .ack    (ack),
    .result (result)
  );

  // euclid by remainder, gcd(0,0) comes out as 0
  function automatic calc_types_pkg::word_t gcd_model(
    input calc_types_pkg::word_t x_in,
    input calc_types_pkg::word_t y_in
  );
    calc_types_pkg::word_t x;
    calc_types_pkg::word_t y;
    calc_types_pkg::word_t t;
    x = x_in;
    y = y_in;
    while (y != '0) begin
      t = x % y;
      x = y;
      y = t;
    end
    return x;
  endfunction

  function automatic calc_types_pkg::word_t expected_word(
    input calc_op_pkg::op_t      op_in,
    input calc_types_pkg::word_t x,
    input calc_types_pkg::word_t y
  );
    calc_types_pkg::word_t exp;
    case (op_in)
      calc_op_pkg::OP_AND: exp = x & y;
      calc_op_pkg::OP_OR:  exp = x | y;
      calc_op_pkg::OP_XOR: exp = x ^ y;
      calc_op_pkg::OP_SUB: exp = x - y;
      calc_op_pkg::OP_LSH: exp = x << y[3:0];
      calc_op_pkg::OP_RSH: exp = x >> y[3:0];
      calc_op_pkg::OP_LT:  exp = (x < y) ? calc_types_pkg::word_t'(1) : '0;
      calc_op_pkg::OP_EQ:  exp = (x == y) ? calc_types_pkg::word_t'(1) : '0;
      calc_op_pkg::OP_MUL: exp = x * y;
      calc_op_pkg::OP_GCD: exp = gcd_model(x, y);
      default:             exp = '0;
    endcase
    return exp;
  endfunction

  // edges from the sampling edge to ack, 0 when the loop length depends on data
  function automatic int expected_latency(input calc_op_pkg::op_t op_in);
    if (op_in == calc_op_pkg::OP_MUL) begin
      return WIDTH + 2;
    end else if (op_in == calc_op_pkg::OP_GCD) begin
      return 0;
    end
    return 3;
  endfunction

  task automatic check_word(
    input string                 name,
    input calc_types_pkg::word_t got,
    input calc_types_pkg::word_t exp
  );
    if (got !== exp) begin
      $display("ERROR time %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR time %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // outputs are read mid-cycle, away from the rising edge
  task automatic wait_sample();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic run_request(
    input int                    idx,
    input calc_op_pkg::op_t      op_in,
    input calc_types_pkg::word_t x,
    input calc_types_pkg::word_t y
  );
    calc_types_pkg::word_t exp;
    int                    lat;
    int                    edges;
    int                    extra;
    int                    errors_before;
    exp           = expected_word(op_in, x, y);
    lat           = expected_latency(op_in);
    extra         = {$random(seed)} % 6;
    errors_before = errors;
    edges         = 0;
    @(posedge clk);
    req <= 1'b1;
    op  <= op_in;
    a   <= x;
    b   <= y;
    // first edge here samples req, ack must stay low until lat edges later
    if (lat > 0) begin
      repeat (lat + 1) begin
        wait_sample();
        edges++;
        check_bit("ack", ack, edges == lat + 1);
      end
    end
    while (!ack) begin
      wait_sample();
      edges++;
    end
    check_word("result", result, exp);
    // requester holds req, result must not move
    repeat (extra) begin
      wait_sample();
      check_bit("ack", ack, 1'b1);
      check_word("result", result, exp);
    end
    @(posedge clk);
    req <= 1'b0;
    wait_sample();
    check_bit("ack", ack, 1'b0);
    if (errors == errors_before) begin
      $display("test %0d op %h a %h b %h result %h latency %0d ok",
               idx, op_in, x, y, result, edges - 1);
    end else begin
      failed_tests++;
      $display("test %0d op %h a %h b %h result %h expected %h mismatch",
               idx, op_in, x, y, result, exp);
    end
  endtask

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    calc_op_pkg::op_t      op_pick;
    calc_types_pkg::word_t x;
    calc_types_pkg::word_t y;
    int                    shape;
    seed         = 32'h334f;
    errors       = 0;
    failed_tests = 0;
    req          = 1'b0;
    op           = '0;
    a            = '0;
    b            = '0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
    end
    @(negedge clk);
    check_bit("ack", ack, 1'b0);
    for (int i = 0; i < NUM_TESTS; i++) begin
      // every code once, undefined ones too, then random codes
      if (i < 16) begin
        op_pick = calc_op_pkg::op_t'(i);
      end else begin
        op_pick = calc_op_pkg::op_t'($random(seed));
      end
      x     = calc_types_pkg::word_t'($random(seed));
      y     = calc_types_pkg::word_t'($random(seed));
      shape = {$random(seed)} % 8;
      if (shape == 0) begin
        y = x;
      end else if (shape == 1) begin
        x = '0;
      end else if (shape == 2) begin
        y = '0;
      end else if (shape == 3) begin
        x = '0;
        y = '0;
      end
      // keeps the subtraction loop short
      if (op_pick == calc_op_pkg::OP_GCD) begin
        x[WIDTH-1:8] = '0;
        y[WIDTH-1:8] = '0;
      end
      run_request(i, op_pick, x, y);
    end
    $display("tests %0d failed %0d errors %0d", NUM_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== calc_top.f ====
design/calc_types_pkg.sv
design/calc_op_pkg.sv
design/calc_core_ops.sv
design/calc_operand_regs.sv
design/calc_step_counter.sv
design/calc_fsm.sv
design/calc_top.sv
bench/calc_clock_gen.sv
bench/calc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module calc_tb -f calc_top.f -o calc_sim

./obj_dir/calc_sim > sim.log
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"
